//--- list.f
+incdir+include
src/ecc_pkg.sv
src/ecc_merge_enc.sv
src/ecc_burst_mem.sv
src/ecc_dec_fix.sv
src/ecc_status_log.sv
src/ecc_top.sv
test/ecc_top_asserts.sv
test/ecc_checker.sv
test/tb_ecc_top.sv

//--- run.sh
#!/bin/sh
# build and run the ECC testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f list.f --top-module tb_ecc_top \
  --Mdir obj_dir -o tb_ecc_top > build.log 2>&1 &&
  ./obj_dir/tb_ecc_top > sim.log 2>&1
grep -q "^TEST PASS$" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- include/tb_items.svh
`ifndef TB_ITEMS_SVH
`define TB_ITEMS_SVH

// one read as the checker sees it, with the burst that was written.
typedef struct packed {
  logic [ecc_pkg::ADDR_WIDTH-1:0] addr;
  ecc_pkg::data_burst_t           data;
  logic [1:0]                     word;        // word that carries the flips.
  logic [7:0]                     flip_a;      // codeword bit, 255 for none.
  logic [7:0]                     flip_b;
  logic                           correct_en;
  logic                           clear_stats; // counts cleared before this read.
} read_item_t;

`endif

//--- test/tb_ecc_top.sv
`timescale 1ns/1ps
`include "tb_items.svh"

module tb_ecc_top import ecc_pkg::*; ();

  localparam int NUM_ENTRIES = 10;
  localparam int READ_TIMEOUT = 20;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           seed;
    logic [1:0]            word;
    logic [7:0]            flip_a;
    logic [7:0]            flip_b;
    logic                  correct_en;
    logic                  clear_stats;
  } stim_entry_t;

  logic clk;
  logic reset;
  logic wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  data_burst_t wr_data;
  code_burst_t wr_flip;
  logic rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic correct_en;
  logic clear_stats;
  logic rd_valid;
  data_burst_t rd_data;
  logic [BURST_WORDS-1:0] ecc_single;
  logic [BURST_WORDS-1:0] ecc_multiple;
  logic [15:0] single_count;
  logic [15:0] multiple_count;
  logic [ADDR_WIDTH-1:0] err_addr;
  logic push;
  read_item_t item;
  int error_count;
  int checked_count;
  int pushed_count;
  int timeout_count;
  stim_entry_t stim [NUM_ENTRIES];
  read_item_t written [2**ADDR_WIDTH];

  ecc_top dut_i (.*);

  ecc_checker chk_i (
    .clk            (clk),
    .reset          (reset),
    .push           (push),
    .item           (item),
    .rd_valid       (rd_valid),
    .rd_data        (rd_data),
    .ecc_single     (ecc_single),
    .ecc_multiple   (ecc_multiple),
    .single_count   (single_count),
    .multiple_count (multiple_count),
    .err_addr       (err_addr),
    .error_count    (error_count),
    .checked_count  (checked_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic write_burst(input stim_entry_t e);
    data_burst_t data;
    code_burst_t flip;
    flip = '0;
    for (int w = 0; w < BURST_WORDS; w++) data[w] = {$urandom, $urandom} ^ {2{e.seed}};
    if (e.flip_a != 8'd255) flip[e.word].raw[e.flip_a[6:0]] = 1'b1;
    if (e.flip_b != 8'd255) flip[e.word].raw[e.flip_b[6:0]] = 1'b1;
    written[e.addr] = '{e.addr, data, e.word, e.flip_a, e.flip_b, e.correct_en, e.clear_stats};
    @(posedge clk);
    wr_en <= 1'b1;
    wr_addr <= e.addr;
    wr_data <= data;
    wr_flip <= flip;
    clear_stats <= e.clear_stats;
    @(posedge clk);
    wr_en <= 1'b0;
    wr_flip <= '0;
    clear_stats <= 1'b0;
  endtask

  // the checker queues the item alongside the read strobe.
  task automatic issue_read(input read_item_t it);
    @(posedge clk);
    rd_en <= 1'b1;
    rd_addr <= it.addr;
    correct_en <= it.correct_en;
    push <= 1'b1;
    item <= it;
    pushed_count++;
  endtask

  task automatic stop_reads();
    @(posedge clk);
    rd_en <= 1'b0;
    push <= 1'b0;
  endtask

  task automatic wait_for_read(input logic [ADDR_WIDTH-1:0] addr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rd_valid && cycles < READ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rd_valid) begin
      $display("timeout: no rd_valid for the read of address %0d", addr);
      timeout_count++;
    end
  endtask

  initial begin
    read_item_t it;
    int cycles;
    void'($urandom(32'hdca9));
    reset = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_flip = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    correct_en = 1'b1;
    clear_stats = 1'b0;
    push = 1'b0;
    item = '0;
    pushed_count = 0;
    timeout_count = 0;
    // addr, seed, word, flip_a, flip_b, correct_en, clear_stats.
    stim[0] = '{4'd1, 32'h0000_1111, 2'd0, 8'd255, 8'd255, 1'b1, 1'b0};
    stim[1] = '{4'd2, 32'h0000_2222, 2'd1, 8'd5, 8'd255, 1'b1, 1'b0};
    stim[2] = '{4'd3, 32'h0000_3333, 2'd1, 8'd5, 8'd255, 1'b0, 1'b0};
    stim[3] = '{4'd4, 32'h0000_4444, 2'd2, 8'd67, 8'd255, 1'b1, 1'b0}; // check bit.
    stim[4] = '{4'd5, 32'h0000_5555, 2'd3, 8'd10, 8'd40, 1'b1, 1'b0};
    stim[5] = '{4'd6, 32'h0000_6666, 2'd0, 8'd63, 8'd70, 1'b1, 1'b0};
    stim[6] = '{4'd7, 32'h0000_7777, 2'd2, 8'd30, 8'd255, 1'b1, 1'b1};
    stim[7] = '{4'd8, 32'h0000_8888, 2'd0, 8'd255, 8'd255, 1'b1, 1'b1};
    stim[8] = '{4'd9, 32'h0000_9999, 2'd3, 8'd56, 8'd255, 1'b0, 1'b0}; // weight-5 column.
    stim[9] = '{4'd10, 32'h0000_aaaa, 2'd1, 8'd0, 8'd1, 1'b0, 1'b0};
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      write_burst(stim[i]);
      @(posedge clk);
      issue_read(written[stim[i].addr]);
      stop_reads();
      wait_for_read(stim[i].addr);
    end
    // two reads in flight.
    it = written[2];
    it.correct_en = 1'b1;
    it.clear_stats = 1'b0;
    issue_read(it);
    it = written[5];
    it.correct_en = 1'b1;
    it.clear_stats = 1'b0;
    issue_read(it);
    stop_reads();
    wait_for_read(4'd2);
    cycles = 0;
    while (checked_count != pushed_count && cycles < READ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (checked_count != pushed_count) begin
      $display("timeout: only %0d of %0d reads were checked", checked_count, pushed_count);
      timeout_count++;
    end
    $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
             error_count, dut_i.asserts_i.fail_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- test/ecc_checker.sv
`timescale 1ns/1ps
`include "tb_items.svh"

module ecc_checker import ecc_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  read_item_t             item,
  input  logic                   rd_valid,
  input  data_burst_t            rd_data,
  input  logic [BURST_WORDS-1:0] ecc_single,
  input  logic [BURST_WORDS-1:0] ecc_multiple,
  input  logic [15:0]            single_count,
  input  logic [15:0]            multiple_count,
  input  logic [ADDR_WIDTH-1:0]  err_addr,
  output int                     error_count,
  output int                     checked_count
);

  read_item_t pending [$];
  read_item_t cur;
  data_burst_t exp_data;
  logic [BURST_WORDS-1:0] exp_single;
  logic [BURST_WORDS-1:0] exp_multiple;
  logic [15:0] exp_single_count;
  logic [15:0] exp_multiple_count;
  logic [ADDR_WIDTH-1:0] exp_err_addr;
  logic counts_due;

  task automatic compare(input string name, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      error_count++;
    end
  endtask

  // one flip is a single error, two flips are a double error.
  task automatic predict(input read_item_t it, output data_burst_t d,
                         output logic [BURST_WORDS-1:0] s, output logic [BURST_WORDS-1:0] mu);
    int flips;
    logic [7:0] pos;
    d = it.data;
    s = '0;
    mu = '0;
    flips = 0;
    if (it.flip_a != 8'd255) flips++;
    if (it.flip_b != 8'd255) flips++;
    if (flips == 1) begin
      s[it.word] = 1'b1;
      pos = (it.flip_a != 8'd255) ? it.flip_a : it.flip_b;
      if (pos < 8'd64 && !it.correct_en) begin
        d[it.word][pos[5:0]] = ~d[it.word][pos[5:0]];
      end
    end else if (flips == 2) begin
      mu[it.word] = 1'b1; // no column matches, so both data flips stay.
      if (it.flip_a < 8'd64) d[it.word][it.flip_a[5:0]] = ~d[it.word][it.flip_a[5:0]];
      if (it.flip_b < 8'd64) d[it.word][it.flip_b[5:0]] = ~d[it.word][it.flip_b[5:0]];
    end
  endtask

  always @(negedge clk) begin
    if (reset) begin
      pending.delete();
      error_count = 0;
      checked_count = 0;
      counts_due = 1'b0;
      exp_single_count = '0;
      exp_multiple_count = '0;
      exp_err_addr = '0;
    end else begin
      if (push) pending.push_back(item);
      // logger updates at the edge after rd_valid.
      if (counts_due) begin
        compare("single_count", 256'(exp_single_count), 256'(single_count));
        compare("multiple_count", 256'(exp_multiple_count), 256'(multiple_count));
        compare("err_addr", 256'(exp_err_addr), 256'(err_addr));
        counts_due = 1'b0;
        checked_count++;
      end
      if (rd_valid) begin
        if (pending.size() == 0) begin
          $display("rd_valid at %0t without any read outstanding", $time);
          error_count++;
        end else begin
          cur = pending.pop_front();
          predict(cur, exp_data, exp_single, exp_multiple);
          compare("rd_data", exp_data, rd_data);
          compare("ecc_single", 256'(exp_single), 256'(ecc_single));
          compare("ecc_multiple", 256'(exp_multiple), 256'(ecc_multiple));
          if (cur.clear_stats) begin
            exp_single_count = '0;
            exp_multiple_count = '0;
          end
          if (|exp_single && exp_single_count != 16'hffff) exp_single_count++;
          if (|exp_multiple && exp_multiple_count != 16'hffff) exp_multiple_count++;
          if (|exp_single || |exp_multiple) exp_err_addr = cur.addr;
          counts_due = 1'b1;
        end
      end
    end
  end

endmodule

//--- test/ecc_top_asserts.sv
`timescale 1ns/1ps

module ecc_top_asserts import ecc_pkg::*; (
  input logic                   clk,
  input logic                   reset,
  input logic                   rd_en,
  input logic                   rd_valid,
  input logic [BURST_WORDS-1:0] ecc_single,
  input logic [BURST_WORDS-1:0] ecc_multiple
);

  int fail_count = 0; // failed assertions so far.

  // a word is either correctable or not, never both.
  flags_exclusive: assert property (@(posedge clk) disable iff (reset)
    (ecc_single & ecc_multiple) == '0)
    else begin
      fail_count++;
      $error("ecc_single and ecc_multiple set on the same word");
    end

  flags_need_valid: assert property (@(posedge clk) disable iff (reset)
    !rd_valid |-> (ecc_single == '0 && ecc_multiple == '0))
    else begin
      fail_count++;
      $error("error flags set outside a rd_valid cycle");
    end

  read_latency: assert property (@(posedge clk) disable iff (reset)
    rd_valid == $past(rd_en, 2))
    else begin
      fail_count++;
      $error("rd_valid does not follow rd_en by two cycles");
    end

endmodule

bind ecc_top ecc_top_asserts asserts_i (
  .clk          (clk),
  .reset        (reset),
  .rd_en        (rd_en),
  .rd_valid     (rd_valid),
  .ecc_single   (ecc_single),
  .ecc_multiple (ecc_multiple)
);

//--- src/ecc_top.sv
`timescale 1ns/1ps

module ecc_top import ecc_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr_en,
  input  logic [ADDR_WIDTH-1:0]  wr_addr,
  input  data_burst_t            wr_data,
  input  code_burst_t            wr_flip,
  input  logic                   rd_en,
  input  logic [ADDR_WIDTH-1:0]  rd_addr,
  input  logic                   correct_en,
  input  logic                   clear_stats,
  output logic                   rd_valid,
  output data_burst_t            rd_data,
  output logic [BURST_WORDS-1:0] ecc_single,
  output logic [BURST_WORDS-1:0] ecc_multiple,
  output logic [15:0]            single_count,
  output logic [15:0]            multiple_count,
  output logic [ADDR_WIDTH-1:0]  err_addr
);

  logic                  enc_we;
  logic [ADDR_WIDTH-1:0] enc_addr;
  code_burst_t           enc_burst;
  logic                  mem_valid;
  code_burst_t           mem_burst;
  logic [ADDR_WIDTH-1:0] rd_addr_d1;
  logic [ADDR_WIDTH-1:0] log_addr;

  ecc_merge_enc u_enc (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_flip   (wr_flip),
    .enc_we    (enc_we),
    .enc_addr  (enc_addr),
    .enc_burst (enc_burst)
  );

  ecc_burst_mem u_mem (
    .clk       (clk),
    .reset     (reset),
    .enc_we    (enc_we),
    .enc_addr  (enc_addr),
    .enc_burst (enc_burst),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .mem_valid (mem_valid),
    .mem_burst (mem_burst)
  );

  ecc_dec_fix u_dec (
    .clk          (clk),
    .reset        (reset),
    .mem_burst    (mem_burst),
    .mem_valid    (mem_valid),
    .correct_en   (correct_en),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .ecc_single   (ecc_single),
    .ecc_multiple (ecc_multiple)
  );

  // address follows the memory and decoder stages.
  always_ff @(posedge clk) begin
    rd_addr_d1 <= rd_addr;
    log_addr   <= rd_addr_d1;
  end

  ecc_status_log u_log (
    .clk            (clk),
    .reset          (reset),
    .clear_stats    (clear_stats),
    .rd_valid       (rd_valid),
    .log_addr       (log_addr),
    .ecc_single     (ecc_single),
    .ecc_multiple   (ecc_multiple),
    .single_count   (single_count),
    .multiple_count (multiple_count),
    .err_addr       (err_addr)
  );

endmodule

//--- src/ecc_status_log.sv
`timescale 1ns/1ps

module ecc_status_log import ecc_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear_stats,
  input  logic                   rd_valid,
  input  logic [ADDR_WIDTH-1:0]  log_addr,
  input  logic [BURST_WORDS-1:0] ecc_single,
  input  logic [BURST_WORDS-1:0] ecc_multiple,
  output logic [15:0]            single_count,
  output logic [15:0]            multiple_count,
  output logic [ADDR_WIDTH-1:0]  err_addr
);

  logic single_hit;
  logic multiple_hit;

  // one count per read, however many words were hit.
  assign single_hit   = rd_valid && (|ecc_single);
  assign multiple_hit = rd_valid && (|ecc_multiple);

  always_ff @(posedge clk) begin
    if (reset) begin
      single_count   <= '0;
      multiple_count <= '0;
    end else if (clear_stats) begin
      single_count   <= '0; // clear beats a same-cycle increment.
      multiple_count <= '0;
    end else begin
      if (single_hit && (single_count != '1)) begin
        single_count <= single_count + 16'd1;
      end
      if (multiple_hit && (multiple_count != '1)) begin
        multiple_count <= multiple_count + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      err_addr <= '0;
    end else if (single_hit || multiple_hit) begin
      err_addr <= log_addr; // last errored burst.
    end
  end

endmodule

//--- src/ecc_dec_fix.sv
`timescale 1ns/1ps

module ecc_dec_fix import ecc_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  code_burst_t            mem_burst,
  input  logic                   mem_valid,
  input  logic                   correct_en,
  output data_burst_t            rd_data,
  output logic                   rd_valid,
  output logic [BURST_WORDS-1:0] ecc_single,
  output logic [BURST_WORDS-1:0] ecc_multiple
);

  logic [CODE_WIDTH-1:0][ECC_WIDTH-1:0] h_cols;
  logic [ECC_WIDTH-1:0][CODE_WIDTH-1:0] h_rows;
  logic [BURST_WORDS-1:0][ECC_WIDTH-1:0] syndrome_ns;
  logic [BURST_WORDS-1:0][ECC_WIDTH-1:0] syndrome_r;
  data_burst_t payload_r;
  logic status_valid_r;
  logic [BURST_WORDS-1:0][DATA_WIDTH-1:0] flip_bits;

  for (genvar n = 0; n < CODE_WIDTH; n++) begin : g_col
    assign h_cols[n] = h_column(n);
    for (genvar m = 0; m < ECC_WIDTH; m++) begin : g_row
      assign h_rows[m][n] = h_cols[n][m];
    end
  end

  always_comb begin
    for (int w = 0; w < BURST_WORDS; w++) begin
      for (int m = 0; m < ECC_WIDTH; m++) begin
        syndrome_ns[w][m] = ^(mem_burst[w].raw & h_rows[m]);
      end
    end
  end

  always_ff @(posedge clk) begin
    syndrome_r <= syndrome_ns;
    for (int w = 0; w < BURST_WORDS; w++) begin
      payload_r[w] <= mem_burst[w].fields.data; // check byte is dropped here.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      status_valid_r <= 1'b0;
    end else begin
      status_valid_r <= mem_valid;
    end
  end

  assign rd_valid = status_valid_r;

  // a data bit is wrong when its column matches the syndrome.
  // check-bit columns never match a data column, so those errors flip nothing.
  always_comb begin
    for (int w = 0; w < BURST_WORDS; w++) begin
      for (int n = 0; n < DATA_WIDTH; n++) begin
        flip_bits[w][n] = (h_cols[n] == syndrome_r[w]);
      end
    end
  end

  always_comb begin
    for (int w = 0; w < BURST_WORDS; w++) begin
      if (correct_en) begin
        rd_data[w] = payload_r[w] ^ flip_bits[w];
      end else begin
        rd_data[w] = payload_r[w];
      end
    end
  end

  // odd weight means one bit in error, even weight means two or more.
  always_comb begin
    for (int w = 0; w < BURST_WORDS; w++) begin
      ecc_single[w]   = status_valid_r && (|syndrome_r[w]) && (^syndrome_r[w]);
      ecc_multiple[w] = status_valid_r && (|syndrome_r[w]) && !(^syndrome_r[w]);
    end
  end

endmodule

//--- src/ecc_burst_mem.sv
`timescale 1ns/1ps

module ecc_burst_mem import ecc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enc_we,
  input  logic [ADDR_WIDTH-1:0] enc_addr,
  input  code_burst_t           enc_burst,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic                  mem_valid,
  output code_burst_t           mem_burst
);

  // one entry per burst address, stands in for the dram.
  code_burst_t mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (enc_we) begin
      mem[enc_addr] <= enc_burst;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      mem_burst <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= rd_en;
    end
  end

endmodule

//--- src/ecc_merge_enc.sv
`timescale 1ns/1ps

module ecc_merge_enc import ecc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  data_burst_t           wr_data,
  input  code_burst_t           wr_flip,
  output logic                  enc_we,
  output logic [ADDR_WIDTH-1:0] enc_addr,
  output code_burst_t           enc_burst
);

  logic [ECC_WIDTH-1:0][DATA_WIDTH-1:0] h_rows;
  code_burst_t clean_burst;
  code_burst_t enc_next;

  // data part of the check matrix, turned into row masks.
  for (genvar n = 0; n < DATA_WIDTH; n++) begin : g_col
    logic [ECC_WIDTH-1:0] col;
    assign col = h_column(n);
    for (genvar m = 0; m < ECC_WIDTH; m++) begin : g_row
      assign h_rows[m][n] = col[m];
    end
  end

  always_comb begin
    for (int w = 0; w < BURST_WORDS; w++) begin
      clean_burst[w].fields.data = wr_data[w];
      for (int m = 0; m < ECC_WIDTH; m++) begin
        clean_burst[w].fields.ecc[m] = ^(wr_data[w] & h_rows[m]);
      end
      enc_next[w].raw = clean_burst[w].raw ^ wr_flip[w].raw; // fault injection.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enc_we <= 1'b0;
    end else begin
      enc_we <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    enc_addr  <= wr_addr;
    enc_burst <= enc_next;
  end

endmodule

//--- src/ecc_pkg.sv
package ecc_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int ECC_WIDTH = 8;
  localparam int CODE_WIDTH = DATA_WIDTH + ECC_WIDTH;
  localparam int BURST_WORDS = 4;
  localparam int ADDR_WIDTH = 4;

  // check byte sits above the data word.
  typedef struct packed {
    logic [ECC_WIDTH-1:0] ecc;
    logic [DATA_WIDTH-1:0] data;
  } code_fields_t;

  // one codeword, seen either as a flat vector or as ecc over data.
  typedef union packed {
    logic [CODE_WIDTH-1:0] raw;
    code_fields_t fields;
  } code_word_u;

  typedef code_word_u [BURST_WORDS-1:0] code_burst_t;

  typedef logic [BURST_WORDS-1:0][DATA_WIDTH-1:0] data_burst_t;

  // hsiao check column of codeword bit n.
  // data bits use all weight-3 bytes, then the lowest weight-5 bytes,
  // each group in ascending order. check bits are unit columns.
  function automatic logic [ECC_WIDTH-1:0] h_column(input int n);
    logic [ECC_WIDTH-1:0] col;
    int idx;
    col = '0;
    idx = 0;
    if (n >= DATA_WIDTH) begin
      col[n-DATA_WIDTH] = 1'b1;
    end else begin
      for (int weight = 3; weight <= 5; weight += 2) begin
        for (int v = 0; v < 2**ECC_WIDTH; v++) begin
          if ($countones(v) == weight) begin
            if (idx == n) col = ECC_WIDTH'(v);
            idx++;
          end
        end
      end
    end
    return col;
  endfunction

endpackage
